//--- common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path and address width
`define XLEN 32

// Destination register index width
`define REG_ADDR_W 5

// Branch history table, entry count must be a power of two
`define BHT_ENTRIES 16
`define BHT_IDX_W 4

`endif

//--- common/core_types_pkg.sv
`include "core_config.svh"

package core_types_pkg;

    // Commands accepted by the branch unit
    // Codes above c_BGEU are illegal
    typedef enum logic [3:0] {
        c_SLT  = 4'd0,
        c_SLTU = 4'd1,
        c_BEQ  = 4'd2,
        c_BNE  = 4'd3,
        c_BLT  = 4'd4,
        c_BGE  = 4'd5,
        c_BLTU = 4'd6,
        c_BGEU = 4'd7
    } alu_cmd_t;

    // One operation as handed over by the issuer
    typedef struct packed {
        alu_cmd_t                   cmd;
        // Compared operands
        logic [`XLEN-1:0]           arg0;
        logic [`XLEN-1:0]           arg1;
        // Branch address and offset
        logic [`XLEN-1:0]           addr;
        logic [`XLEN-1:0]           imm;
        logic [`REG_ADDR_W-1:0]     rd;
    } issue_op_t;

endpackage

//--- common/branch_types_pkg.sv
`include "core_config.svh"

package branch_types_pkg;

    // Result handed to the commit side
    typedef struct packed {
        // 0/1 for SLT/SLTU, target address for branches
        logic [`XLEN-1:0]           value;
        logic [`REG_ADDR_W-1:0]     rd;
        logic                       is_branch;
        logic                       taken;
        logic                       mispredict;
        logic                       illegal;
        // Carry out of the target addition
        logic                       overflow;
    } resolved_t;

    // Training request for one predictor counter
    typedef struct packed {
        logic                       valid;
        logic [`BHT_IDX_W-1:0]      idx;
        logic                       taken;
    } bht_update_t;

endpackage

//--- hdl/branch_issue.sv
module branch_issue (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_issue_req,
    input  core_types_pkg::issue_op_t i_issue_op,
    output logic                      o_issue_ack,
    input  logic                      i_busy,
    output logic                      o_launch,
    output core_types_pkg::issue_op_t o_op
);

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_DROP
    } state_t;

    state_t state;

    // Input side of the four-phase handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            o_issue_ack <= 1'b0;
            o_launch    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // Hold off while a previous result is still pending
                    if (i_issue_req && !i_busy) begin
                        state       <= ACK;
                        o_issue_ack <= 1'b1;
                        o_launch    <= 1'b1;
                    end
                end
                ACK: begin
                    // Launch lasts a single cycle
                    state    <= WAIT_DROP;
                    o_launch <= 1'b0;
                end
                WAIT_DROP: begin
                    if (!i_issue_req) begin
                        state       <= IDLE;
                        o_issue_ack <= 1'b0;
                    end
                end
                default: begin
                    state       <= IDLE;
                    o_issue_ack <= 1'b0;
                    o_launch    <= 1'b0;
                end
            endcase
        end
    end

    // Keep a private copy, the issuer may change its bus after ack
    always_ff @(posedge clk) begin
        if (state == IDLE && i_issue_req && !i_busy) begin
            o_op <= i_issue_op;
        end
    end

endmodule

//--- branch_unit/branch_predictor.sv
`include "core_config.svh"

module branch_predictor (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`XLEN-1:0]              i_addr,
    output logic                          o_predict_taken,
    input  branch_types_pkg::bht_update_t i_update
);

    logic [1:0] counters [`BHT_ENTRIES];
    logic [1:0] cur_cnt;
    logic [1:0] next_cnt;

    // Word aligned index, low two address bits skipped
    assign o_predict_taken = counters[i_addr[`BHT_IDX_W+1:2]][1];

    assign cur_cnt = counters[i_update.idx];

    // Saturating 2-bit counter step
    always_comb begin
        next_cnt = cur_cnt;
        if (i_update.taken) begin
            if (cur_cnt != 2'b11) begin
                next_cnt = cur_cnt + 2'b01;
            end
        end else begin
            if (cur_cnt != 2'b00) begin
                next_cnt = cur_cnt - 2'b01;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // All entries start weakly not-taken
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (i_update.valid) begin
            counters[i_update.idx] <= next_cnt;
        end
    end

endmodule

//--- branch_unit/branch_alu.sv
`include "core_config.svh"

module branch_alu (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_launch,
    input  core_types_pkg::issue_op_t     i_op,
    input  logic                          i_predict_taken,
    output logic                          o_done,
    output branch_types_pkg::resolved_t   o_res,
    output branch_types_pkg::bht_update_t o_update
);

    logic [`XLEN:0]              target;
    logic                        eq;
    logic                        lt_s;
    logic                        lt_u;
    logic                        cond;
    branch_types_pkg::resolved_t res_d;

    // One extra bit catches the carry of the target addition
    assign target = {1'b0, i_op.addr} + {1'b0, i_op.imm};

    assign eq   = (i_op.arg0 == i_op.arg1);
    assign lt_s = ($signed(i_op.arg0) < $signed(i_op.arg1));
    assign lt_u = (i_op.arg0 < i_op.arg1);

    always_comb begin
        res_d           = '0;
        res_d.rd        = i_op.rd;
        cond            = 1'b0;
        case (i_op.cmd)
            core_types_pkg::c_SLT:  res_d.value = {{(`XLEN-1){1'b0}}, lt_s};
            core_types_pkg::c_SLTU: res_d.value = {{(`XLEN-1){1'b0}}, lt_u};
            core_types_pkg::c_BEQ: begin
                res_d.is_branch = 1'b1;
                cond            = eq;
            end
            core_types_pkg::c_BNE: begin
                res_d.is_branch = 1'b1;
                cond            = !eq;
            end
            core_types_pkg::c_BLT: begin
                res_d.is_branch = 1'b1;
                cond            = lt_s;
            end
            core_types_pkg::c_BGE: begin
                res_d.is_branch = 1'b1;
                cond            = !lt_s;
            end
            core_types_pkg::c_BLTU: begin
                res_d.is_branch = 1'b1;
                cond            = lt_u;
            end
            core_types_pkg::c_BGEU: begin
                res_d.is_branch = 1'b1;
                cond            = !lt_u;
            end
            // Unused codes give a zero value
            default: res_d.illegal = 1'b1;
        endcase

        if (res_d.is_branch) begin
            res_d.value      = target[`XLEN-1:0];
            res_d.overflow   = target[`XLEN];
            res_d.taken      = cond;
            res_d.mispredict = cond ^ i_predict_taken;
        end
    end

    // Done and training leave together, one cycle after launch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_done   <= 1'b0;
            o_update <= '0;
        end else begin
            o_done         <= i_launch;
            o_update.valid <= i_launch && res_d.is_branch;
            o_update.idx   <= i_op.addr[`BHT_IDX_W+1:2];
            o_update.taken <= cond;
        end
    end

    always_ff @(posedge clk) begin
        if (i_launch) begin
            o_res <= res_d;
        end
    end

endmodule

//--- hdl/branch_commit.sv
module branch_commit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_launch,
    input  logic                        i_done,
    input  branch_types_pkg::resolved_t i_res,
    output logic                        o_busy,
    output logic                        o_commit_req,
    output branch_types_pkg::resolved_t o_commit_res,
    input  logic                        i_commit_ack
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_DROP
    } state_t;

    state_t state;

    // Output side of the four-phase handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            o_commit_req <= 1'b0;
            o_busy       <= 1'b0;
        end else begin
            // Busy spans launch through the end of the commit handshake
            if (i_launch) begin
                o_busy <= 1'b1;
            end else if (state == WAIT_DROP && !i_commit_ack) begin
                o_busy <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (i_done) begin
                        state        <= REQ;
                        o_commit_req <= 1'b1;
                    end
                end
                REQ: begin
                    if (i_commit_ack) begin
                        state        <= WAIT_DROP;
                        o_commit_req <= 1'b0;
                    end
                end
                WAIT_DROP: begin
                    if (!i_commit_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state        <= IDLE;
                    o_commit_req <= 1'b0;
                end
            endcase
        end
    end

    // Result held stable for the whole request phase
    always_ff @(posedge clk) begin
        if (i_done) begin
            o_commit_res <= i_res;
        end
    end

endmodule

//--- hdl/branch_exec_top.sv
module branch_exec_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_issue_req,
    input  core_types_pkg::issue_op_t   i_issue_op,
    output logic                        o_issue_ack,
    output logic                        o_commit_req,
    output branch_types_pkg::resolved_t o_commit_res,
    input  logic                        i_commit_ack
);

    logic                          busy;
    logic                          launch;
    logic                          done;
    logic                          predict_taken;
    core_types_pkg::issue_op_t     op;
    branch_types_pkg::resolved_t   res;
    branch_types_pkg::bht_update_t update;

    branch_issue u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_issue_req (i_issue_req),
        .i_issue_op  (i_issue_op),
        .o_issue_ack (o_issue_ack),
        .i_busy      (busy),
        .o_launch    (launch),
        .o_op        (op)
    );

    // Prediction is looked up from the captured branch address
    branch_predictor u_predictor (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (op.addr),
        .o_predict_taken (predict_taken),
        .i_update        (update)
    );

    branch_alu u_alu (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_launch        (launch),
        .i_op            (op),
        .i_predict_taken (predict_taken),
        .o_done          (done),
        .o_res           (res),
        .o_update        (update)
    );

    branch_commit u_commit (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_launch     (launch),
        .i_done       (done),
        .i_res        (res),
        .o_busy       (busy),
        .o_commit_req (o_commit_req),
        .o_commit_res (o_commit_res),
        .i_commit_ack (i_commit_ack)
    );

endmodule

//--- verif/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Reset held low for a few clock edges
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

//--- verif/tb_branch_exec.sv
`include "core_config.svh"

module tb_branch_exec;

    localparam int TIMEOUT     = 100;
    localparam int KIND_SLT    = 0;
    localparam int KIND_BRANCH = 1;
    localparam int KIND_HOT    = 2;
    localparam int KIND_MIX    = 3;

    logic                        clk;
    logic                        rst_n;
    logic                        issue_req;
    core_types_pkg::issue_op_t   issue_op;
    logic                        issue_ack;
    logic                        commit_req;
    branch_types_pkg::resolved_t commit_res;
    logic                        commit_ack;

    integer seed = 32'hf02c_abca;
    int     cycle = 0;
    int     commit_count = 0;
    int     bht_model [`BHT_ENTRIES];
    logic [`XLEN-1:0] hot_addr [3] = '{32'h0000_1004, 32'h8000_0038, 32'hffff_fffc};

    branch_types_pkg::resolved_t expected_q [$];
    int                          issue_cycle_q [$];

    logic                        prev_issue_ack = 1'b0;
    logic                        prev_commit_req = 1'b0;
    logic                        prev_commit_ack = 1'b0;
    branch_types_pkg::resolved_t prev_commit_res;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(4)) u_clock_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    branch_exec_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_issue_req  (issue_req),
        .i_issue_op   (issue_op),
        .o_issue_ack  (issue_ack),
        .o_commit_req (commit_req),
        .o_commit_res (commit_res),
        .i_commit_ack (commit_ack)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            stop_on_error("Value check failed");
        end
    endtask

    // Expected result from the ISA rules, trains the model counters
    function automatic branch_types_pkg::resolved_t model_resolve(
        input core_types_pkg::issue_op_t op
    );
        branch_types_pkg::resolved_t r;
        longint unsigned             total;
        logic signed [`XLEN-1:0]     a_s;
        logic signed [`XLEN-1:0]     b_s;
        int                          idx;
        logic                        predicted;
        r     = '0;
        r.rd  = op.rd;
        a_s   = op.arg0;
        b_s   = op.arg1;
        idx   = op.addr[`BHT_IDX_W+1:2];
        total = longint'(op.addr) + longint'(op.imm);
        r.is_branch = 1'b1;
        case (op.cmd)
            core_types_pkg::c_SLT: begin
                r.is_branch = 1'b0;
                r.value     = (a_s < b_s) ? 1 : 0;
            end
            core_types_pkg::c_SLTU: begin
                r.is_branch = 1'b0;
                r.value     = (op.arg0 < op.arg1) ? 1 : 0;
            end
            core_types_pkg::c_BEQ:  r.taken = (op.arg0 == op.arg1);
            core_types_pkg::c_BNE:  r.taken = (op.arg0 != op.arg1);
            core_types_pkg::c_BLT:  r.taken = (a_s < b_s);
            core_types_pkg::c_BGE:  r.taken = (a_s >= b_s);
            core_types_pkg::c_BLTU: r.taken = (op.arg0 < op.arg1);
            core_types_pkg::c_BGEU: r.taken = (op.arg0 >= op.arg1);
            default: begin
                r.is_branch = 1'b0;
                r.illegal   = 1'b1;
            end
        endcase
        if (r.is_branch) begin
            predicted    = (bht_model[idx] >= 2);
            r.mispredict = (r.taken != predicted);
            r.value      = total[`XLEN-1:0];
            r.overflow   = total[`XLEN];
            // Saturating counter between 0 and 3
            if (r.taken && bht_model[idx] < 3) begin
                bht_model[idx]++;
            end else if (!r.taken && bht_model[idx] > 0) begin
                bht_model[idx]--;
            end
        end
        return r;
    endfunction

    function automatic core_types_pkg::issue_op_t make_op(input int kind);
        core_types_pkg::issue_op_t op;
        int                        pick;
        int                        code;
        op.arg0 = $random(seed);
        op.arg1 = $random(seed);
        op.addr = $random(seed);
        op.imm  = $random(seed);
        op.rd   = $random(seed);
        pick    = {$random(seed)} % 4;
        // Equal operands, or operands that differ only in sign
        if (pick == 0) begin
            op.arg1 = op.arg0;
        end else if (pick == 1) begin
            op.arg1 = op.arg0 ^ 32'h8000_0000;
        end
        case (kind)
            KIND_SLT:    code = {$random(seed)} % 2;
            KIND_BRANCH: code = 2 + {$random(seed)} % 6;
            KIND_HOT: begin
                op.addr = hot_addr[{$random(seed)} % 3];
                code    = 2 + {$random(seed)} % 6;
                if ({$random(seed)} % 4 == 0) begin
                    code = 8 + {$random(seed)} % 8;
                end
            end
            default: begin
                code = {$random(seed)} % 9;
                if (code == 8) begin
                    code = 8 + {$random(seed)} % 8;
                end
            end
        endcase
        op.cmd = core_types_pkg::alu_cmd_t'(code);
        return op;
    endfunction

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!rst_n) begin
            n++;
            if (n > TIMEOUT) begin
                stop_on_error("Timeout waiting for reset release");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_issue_ack(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (issue_ack !== level) begin
            n++;
            if (n > TIMEOUT) begin
                stop_on_error($sformatf("Timeout waiting for o_issue_ack to become %0b", level));
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_commit_req(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (commit_req !== level) begin
            n++;
            if (n > TIMEOUT) begin
                stop_on_error($sformatf("Timeout waiting for o_commit_req to become %0b", level));
            end
            @(negedge clk);
        end
    endtask

    // Issuer side of the four-phase handshake
    task automatic issue_send(input core_types_pkg::issue_op_t op);
        @(posedge clk);
        issue_req <= 1'b1;
        issue_op  <= op;
        @(negedge clk);
        issue_cycle_q.push_back(cycle);
        wait_issue_ack(1'b1);
        @(posedge clk);
        issue_req <= 1'b0;
        // Bus garbage after ack, the DUT must hold its own copy
        issue_op  <= make_op(KIND_MIX);
        wait_issue_ack(1'b0);
    endtask

    // Committer side, checks each result against the model
    task automatic commit_take(input int delay, input bit check_latency);
        branch_types_pkg::resolved_t exp;
        int                          issued_at;
        string                       tag;
        wait_commit_req(1'b1);
        if (expected_q.size() == 0) begin
            stop_on_error("Commit request arrived with no operation outstanding");
        end
        exp       = expected_q.pop_front();
        issued_at = issue_cycle_q.pop_front();
        tag       = $sformatf("op %0d", commit_count);
        commit_count++;
        if (check_latency) begin
            check_value({tag, " latency"}, 3, cycle - issued_at);
        end
        check_value({tag, " value"}, exp.value, commit_res.value);
        check_value({tag, " rd"}, exp.rd, commit_res.rd);
        check_value({tag, " is_branch"}, exp.is_branch, commit_res.is_branch);
        check_value({tag, " taken"}, exp.taken, commit_res.taken);
        check_value({tag, " mispredict"}, exp.mispredict, commit_res.mispredict);
        check_value({tag, " illegal"}, exp.illegal, commit_res.illegal);
        check_value({tag, " overflow"}, exp.overflow, commit_res.overflow);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        commit_ack <= 1'b1;
        wait_commit_req(1'b0);
        @(posedge clk);
        commit_ack <= 1'b0;
    endtask

    task automatic run_batch(input int count, input int kind, input int max_delay,
                             input bit check_latency);
        core_types_pkg::issue_op_t op;
        fork
            begin
                for (int k = 0; k < count; k++) begin
                    repeat ({$random(seed)} % (max_delay + 1)) @(posedge clk);
                    op = make_op(kind);
                    expected_q.push_back(model_resolve(op));
                    issue_send(op);
                end
            end
            begin
                for (int k = 0; k < count; k++) begin
                    commit_take({$random(seed)} % (max_delay + 1), check_latency);
                end
            end
        join
    endtask

    // Handshake rules watched on every cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (issue_ack && !prev_issue_ack && (commit_req || prev_commit_req)) begin
                stop_on_error("o_issue_ack rose while a commit request was pending");
            end
            if (prev_commit_req && !prev_commit_ack) begin
                check_value("commit request held until ack", 1, commit_req);
            end
            if (prev_commit_req && commit_req) begin
                check_value("commit result stable", prev_commit_res, commit_res);
            end
        end
        prev_issue_ack  = issue_ack;
        prev_commit_req = commit_req;
        prev_commit_ack = commit_ack;
        prev_commit_res = commit_res;
    end

    initial begin
        issue_req  = 1'b0;
        issue_op   = '0;
        commit_ack = 1'b0;
        for (int i = 0; i < `BHT_ENTRIES; i++) begin
            bht_model[i] = 1;
        end
        @(negedge clk);
        wait_reset_release();
        @(negedge clk);
        check_value("reset o_issue_ack", 0, issue_ack);
        check_value("reset o_commit_req", 0, commit_req);

        // Idle DUT with immediate acks, fixed latency
        for (int i = 0; i < 10; i++) begin
            run_batch(1, KIND_BRANCH, 0, 1'b1);
        end
        for (int i = 0; i < 10; i++) begin
            run_batch(1, KIND_SLT, 0, 1'b1);
        end

        // Repeated addresses train the counters, slow committer
        run_batch(60, KIND_HOT, 5, 1'b0);
        run_batch(200, KIND_MIX, 5, 1'b0);

        $display("Everything OK");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/core_types_pkg.sv
common/branch_types_pkg.sv
hdl/branch_issue.sv
branch_unit/branch_predictor.sv
branch_unit/branch_alu.sv
hdl/branch_commit.sv
hdl/branch_exec_top.sv
verif/tb_clock_gen.sv
verif/tb_branch_exec.sv
